//--- verilog.f
+incdir+.
encoder_cmd_pkg.sv
encoder_sample_pkg.sv
encoder_channel.sv
config_decoder.sv
report_arbiter.sv
encoder_hub.sv
tb_as5311_model.sv
tb_encoder_hub.sv

//--- Bender.yml
package:
  name: encoder_hub

sources:
  - include_dirs:
      - .
    files:
      - encoder_cmd_pkg.sv
      - encoder_sample_pkg.sv
      - encoder_channel.sv
      - config_decoder.sv
      - report_arbiter.sv
      - encoder_hub.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_as5311_model.sv
      - tb_encoder_hub.sv

//--- tb_encoder_hub.sv
`timescale 1ns/1ps
`include "encoder_settings.svh"

module tb_encoder_hub
	import encoder_sample_pkg::*;
();

	localparam int IV_DATA = 300;
	localparam int IV_MAG = 250;
	// Intervals of tests three to six, three times over, plus slack for reset and commands.
	localparam int TIMEOUT_CYCLES = 3 * (3 * IV_DATA + 3 * IV_MAG) + 200;

	logic                       clk;
	logic                       arst_n;
	logic [31:0]                systime = '0;
	logic [7:0]                 cmd;
	logic                       cmd_ready;
	logic [31:0]                arg_data;
	logic                       cmd_done;
	logic [32:0]                param_data;
	logic                       param_write;
	logic                       invol_req;
	logic                       invol_grant;
	logic                       daq_req;
	logic                       daq_grant;
	logic [31:0]                daq_data;
	logic                       daq_valid;
	logic                       daq_end;
	logic [`ENC_CHANNELS-1:0]   as5311_clk;
	logic [`ENC_CHANNELS-1:0]   as5311_cs;
	logic [`ENC_CHANNELS-1:0]   as5311_do;
	logic [`ENC_FRAME_BITS-1:0] model_val [`ENC_CHANNELS];
	int                         seed;
	int                         cycle = 0;
	int                         rsp_word = 0;
	int                         errors = 0;
	int                         errors_mark = 0;
	int                         tests_run = 0;
	int                         tests_failed = 0;
	int                         exp_chan;
	logic                       exp_daq;
	logic                       exp_is_data;
	logic [31:0]                exp_iv;
	logic [31:0]                cfg_time;
	daq_head_t                  exp_head;
	logic                       quiet;

	encoder_hub encoder_hub_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.systime     (systime),
		.cmd         (cmd),
		.cmd_ready   (cmd_ready),
		.arg_data    (arg_data),
		.cmd_done    (cmd_done),
		.param_data  (param_data),
		.param_write (param_write),
		.invol_req   (invol_req),
		.invol_grant (invol_grant),
		.daq_req     (daq_req),
		.daq_grant   (daq_grant),
		.daq_data    (daq_data),
		.daq_valid   (daq_valid),
		.daq_end     (daq_end),
		.as5311_clk  (as5311_clk),
		.as5311_cs   (as5311_cs),
		.as5311_do   (as5311_do)
	);

	for (genvar i = 0; i < `ENC_CHANNELS; i++) begin : g_sensor
		tb_as5311_model sensor_inst (
			.sensor_clk (as5311_clk[i]),
			.sensor_cs  (as5311_cs[i]),
			.value      (model_val[i]),
			.sensor_do  (as5311_do[i])
		);
	end

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		systime <= systime + 32'd1;
		rsp_word <= param_write ? rsp_word + 1 : 0; // Index of the response word on the bus.
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("timeout: the run hung, nothing finished within %0d cycles", cycle);
			$display("sim failed");
			$finish;
		end
	end

	// A frame starts at its first deadline, which is one interval after the config write.
	function automatic bit start_in_window(input logic [31:0] t);
		return t >= cfg_time + exp_iv - 2 && t <= cfg_time + exp_iv + 2;
	endfunction

	assert property (@(posedge clk) cycle >= 1 && cycle <= 6 |->
		as5311_cs == '1 && as5311_clk == '1 && !cmd_done && !param_write &&
		!invol_req && !daq_req && !daq_valid && !daq_end)
	else begin
		$write("CHECK FAILED t=%0t reset outputs got cs=%b clk=%b done=%b pw=%b req=%b%b dv=%b de=%b",
			$time, $sampled(as5311_cs), $sampled(as5311_clk), $sampled(cmd_done),
			$sampled(param_write), $sampled(invol_req), $sampled(daq_req),
			$sampled(daq_valid), $sampled(daq_end));
		$display(" expected cs=11 clk=11 and every strobe and request 0");
		errors++;
	end

	assert property (@(posedge clk) disable iff (!arst_n)
		cmd_ready && cmd == `ENC_CMD_CONFIG |-> !cmd_done [*5] ##1 cmd_done)
	else begin
		$display("t=%0t cmd_done did not come exactly five cycles after a config command", $time);
		errors++;
	end

	assert property (@(posedge clk) disable iff (!arst_n)
		cmd_ready && cmd != `ENC_CMD_CONFIG |-> ##1 cmd_done ##1 !cmd_done)
	else begin
		$display("t=%0t cmd_done did not come one cycle after an unknown command", $time);
		errors++;
	end

	assert property (@(posedge clk) disable iff (!arst_n)
		!(param_write && exp_daq) && !(daq_valid && !exp_daq))
	else begin
		$display("t=%0t a frame was sent on the wrong path for its use_daq setting", $time);
		errors++;
	end

	assert property (@(posedge clk) disable iff (!arst_n)
		param_write && rsp_word == 0 |-> param_data == 33'(exp_chan))
	else begin
		$display("CHECK FAILED t=%0t param_data channel got %0h expected %0h",
			$time, $sampled(param_data), exp_chan);
		errors++;
	end

	assert property (@(posedge clk) disable iff (!arst_n)
		param_write && rsp_word == 1 |-> start_in_window(param_data[31:0]))
	else begin
		$display("CHECK FAILED t=%0t param_data start time got %0d expected %0d to %0d",
			$time, $sampled(param_data), cfg_time + exp_iv - 2, cfg_time + exp_iv + 2);
		errors++;
	end

	assert property (@(posedge clk) disable iff (!arst_n)
		param_write && rsp_word == 2 |-> param_data == 33'(model_val[exp_chan]))
	else begin
		$display("CHECK FAILED t=%0t param_data value got %0h expected %0h",
			$time, $sampled(param_data), model_val[exp_chan]);
		errors++;
	end

	assert property (@(posedge clk) disable iff (!arst_n)
		param_write && rsp_word == 3 |-> param_data == 33'(exp_is_data))
	else begin
		$display("CHECK FAILED t=%0t param_data is_data got %0h expected %0h",
			$time, $sampled(param_data), exp_is_data);
		errors++;
	end

	// The fourth word closes the response, then the response code comes with cmd_done.
	assert property (@(posedge clk) disable iff (!arst_n)
		$fell(param_write) |-> rsp_word == 4 && cmd_done && param_data == `ENC_RSP_DATA)
	else begin
		$write("CHECK FAILED t=%0t response end got words=%0d done=%b data=%h",
			$time, $sampled(rsp_word), $sampled(cmd_done), $sampled(param_data));
		$display(" expected words=4 done=1 data=%h", `ENC_RSP_DATA);
		errors++;
	end

	assert property (@(posedge clk) disable iff (!arst_n)
		daq_valid && !daq_end |-> daq_data == exp_head)
	else begin
		$display("CHECK FAILED t=%0t daq_data head got %h expected %h",
			$time, $sampled(daq_data), exp_head);
		errors++;
	end

	assert property (@(posedge clk) disable iff (!arst_n)
		daq_end |-> start_in_window(daq_data))
	else begin
		$display("CHECK FAILED t=%0t daq_data start time got %0d expected %0d to %0d",
			$time, $sampled(daq_data), cfg_time + exp_iv - 2, cfg_time + exp_iv + 2);
		errors++;
	end

	// Data frames begin with the sensor clock high, magnitude frames with it low.
	assert property (@(posedge clk) disable iff (!arst_n)
		$fell(as5311_cs[exp_chan]) |-> as5311_clk[exp_chan] == exp_is_data)
	else begin
		$display("CHECK FAILED t=%0t as5311_clk at cs fall got %b expected %b",
			$time, $sampled(as5311_clk[exp_chan]), exp_is_data);
		errors++;
	end

	assert property (@(posedge clk) disable iff (!arst_n)
		quiet |-> as5311_cs == '1 && !invol_req && !daq_req)
	else begin
		$display("CHECK FAILED t=%0t disabled hub got cs=%b req=%b%b expected cs=11 req=00",
			$time, $sampled(as5311_cs), $sampled(invol_req), $sampled(daq_req));
		errors++;
	end

	task automatic send_config(input int chan, input int div, input int data_iv,
		input int mag_iv, input bit daq);
		@(posedge clk);
		cmd <= `ENC_CMD_CONFIG;
		cmd_ready <= 1'b1;
		arg_data <= 32'(chan);
		@(posedge clk);
		cmd_ready <= 1'b0;
		arg_data <= 32'(div);
		@(posedge clk);
		arg_data <= 32'(data_iv);
		@(posedge clk);
		arg_data <= 32'(mag_iv);
		@(posedge clk);
		arg_data <= 32'(daq);
		do @(negedge clk); while (!cmd_done);
		cfg_time = systime;
	endtask

	task automatic send_other(input logic [7:0] code);
		@(posedge clk);
		cmd <= code;
		cmd_ready <= 1'b1;
		@(posedge clk);
		cmd_ready <= 1'b0;
		do @(negedge clk); while (!cmd_done);
	endtask

	// Runs one frame through a channel on the chosen path, then switches the channel off.
	task automatic frame_test(input int chan, input int div, input int data_iv,
		input int mag_iv, input bit daq);
		exp_chan = chan;
		exp_daq = daq;
		exp_is_data = data_iv != 0;
		exp_iv = (data_iv != 0) ? 32'(data_iv) : 32'(mag_iv);
		exp_head.tag = exp_is_data ? `ENC_DAQ_TAG_DAT : `ENC_DAQ_TAG_MAG;
		exp_head.chan = 6'(chan);
		exp_head.value = model_val[chan];
		send_config(chan, div, data_iv, mag_iv, daq);
		do @(negedge clk); while (!(daq ? daq_req : invol_req));
		@(posedge clk);
		@(posedge clk);
		if (daq)
			daq_grant <= 1'b1;
		else
			invol_grant <= 1'b1;
		@(posedge clk);
		daq_grant <= 1'b0;
		invol_grant <= 1'b0;
		do @(negedge clk); while (!(daq ? daq_end : cmd_done));
		send_config(chan, 0, 0, 0, 0);
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != errors_mark)
			tests_failed++;
		$display("test %0d %s: %s", tests_run, name, (errors != errors_mark) ? "FAILED" : "ok");
		errors_mark = errors;
	endtask

	initial begin
		arst_n = 1'b0;
		cmd = '0;
		cmd_ready = 1'b0;
		arg_data = '0;
		invol_grant = 1'b0;
		daq_grant = 1'b0;
		exp_chan = 0;
		exp_daq = 1'b0;
		exp_is_data = 1'b1;
		exp_iv = '0;
		cfg_time = '0;
		exp_head = '0;
		quiet = 1'b0;
		seed = 74167;
		for (int i = 0; i < `ENC_CHANNELS; i++)
			model_val[i] = `ENC_FRAME_BITS'($random(seed));
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		repeat (3) @(posedge clk);
		end_test("reset state");

		send_other(8'h07);
		send_config(0, 0, 0, 0, 0);
		end_test("command timing");

		frame_test(0, 2, IV_DATA, 0, 1'b0);
		end_test("response path");

		frame_test(1, 2, IV_DATA, 0, 1'b1);
		end_test("daq path");

		frame_test(0, 3, 0, IV_MAG, 1'b0);
		frame_test(1, 2, 0, IV_MAG, 1'b1);
		end_test("magnitude frames");

		send_config(0, 2, IV_DATA, 0, 0);
		send_config(1, 2, 0, IV_MAG, 1);
		// The timers keep running here, only the zero divider keeps the sensors idle.
		send_config(0, 0, IV_DATA, 0, 0);
		send_config(1, 0, 0, IV_MAG, 1);
		quiet = 1'b1;
		repeat (2 * IV_DATA) @(negedge clk);
		quiet = 1'b0;
		end_test("disable");

		$display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- tb_as5311_model.sv
`timescale 1ns/1ps
`include "encoder_settings.svh"

module tb_as5311_model (
	input  logic                       sensor_clk,
	input  logic                       sensor_cs,
	input  logic [`ENC_FRAME_BITS-1:0] value,
	output logic                       sensor_do
);

	logic [`ENC_FRAME_BITS-1:0] shift_q;

	initial begin
		shift_q = '0;
		sensor_do = 1'b0;
	end

	// Chip select fall loads the word and puts its MSB on the line.
	always @(negedge sensor_cs) begin
		shift_q = value;
		sensor_do = value[`ENC_FRAME_BITS-1];
	end

	always @(negedge sensor_clk) begin
		if (!sensor_cs) begin
			shift_q = shift_q << 1;
			sensor_do = shift_q[`ENC_FRAME_BITS-1]; // Next bit follows each falling clock.
		end
	end

endmodule

//--- encoder_hub.sv
`timescale 1ns/1ps
`include "encoder_settings.svh"

module encoder_hub
	import encoder_cmd_pkg::*;
	import encoder_sample_pkg::*;
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic [31:0]              systime,
	input  logic [7:0]               cmd,
	input  logic                     cmd_ready,
	input  logic [31:0]              arg_data,
	output logic                     cmd_done,
	output logic [32:0]              param_data,
	output logic                     param_write,
	output logic                     invol_req,
	input  logic                     invol_grant,
	output logic                     daq_req,
	input  logic                     daq_grant,
	output logic [31:0]              daq_data,
	output logic                     daq_valid,
	output logic                     daq_end,
	output logic [`ENC_CHANNELS-1:0] as5311_clk,
	output logic [`ENC_CHANNELS-1:0] as5311_cs,
	input  logic [`ENC_CHANNELS-1:0] as5311_do
);

	logic                     dec_done;
	logic                     arb_done;
	logic                     arb_busy;
	logic                     cfg_write;
	chan_sel_t                cfg_sel;
	chan_cfg_t                cfg;
	logic [`ENC_CHANNELS-1:0] frame_valid;
	logic [`ENC_CHANNELS-1:0] frame_ack;
	logic [`ENC_CHANNELS-1:0] use_daq;
	frame_t                   frames [`ENC_CHANNELS];

	// The decoder only runs while the arbiter is idle, so the pulses never overlap.
	assign cmd_done = dec_done | arb_done;

	config_decoder config_decoder_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.systime   (systime),
		.cmd       (cmd),
		.cmd_ready (cmd_ready),
		.arg_data  (arg_data),
		.arb_busy  (arb_busy),
		.cfg_write (cfg_write),
		.cfg_sel   (cfg_sel),
		.cfg       (cfg),
		.cmd_done  (dec_done)
	);

	for (genvar i = 0; i < `ENC_CHANNELS; i++) begin : g_chan
		encoder_channel encoder_channel_inst (
			.clk         (clk),
			.arst_n      (arst_n),
			.systime     (systime),
			.cfg_write   (cfg_write && cfg_sel == chan_sel_t'(i)),
			.cfg         (cfg),
			.sensor_do   (as5311_do[i]),
			.frame_ack   (frame_ack[i]),
			.sensor_clk  (as5311_clk[i]),
			.sensor_cs   (as5311_cs[i]),
			.frame_valid (frame_valid[i]),
			.frame       (frames[i]),
			.use_daq     (use_daq[i])
		);
	end

	report_arbiter report_arbiter_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.frame_valid (frame_valid),
		.frames      (frames),
		.use_daq     (use_daq),
		.invol_grant (invol_grant),
		.daq_grant   (daq_grant),
		.frame_ack   (frame_ack),
		.invol_req   (invol_req),
		.daq_req     (daq_req),
		.param_data  (param_data),
		.param_write (param_write),
		.daq_data    (daq_data),
		.daq_valid   (daq_valid),
		.daq_end     (daq_end),
		.cmd_done    (arb_done),
		.arb_busy    (arb_busy)
	);

endmodule

//--- report_arbiter.sv
`timescale 1ns/1ps
`include "encoder_settings.svh"

module report_arbiter
	import encoder_cmd_pkg::*;
	import encoder_sample_pkg::*;
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic [`ENC_CHANNELS-1:0] frame_valid,
	input  frame_t                   frames [`ENC_CHANNELS],
	input  logic [`ENC_CHANNELS-1:0] use_daq,
	input  logic                     invol_grant,
	input  logic                     daq_grant,
	output logic [`ENC_CHANNELS-1:0] frame_ack,
	output logic                     invol_req,
	output logic                     daq_req,
	output logic [32:0]              param_data,
	output logic                     param_write,
	output logic [31:0]              daq_data,
	output logic                     daq_valid,
	output logic                     daq_end,
	output logic                     cmd_done,
	output logic                     arb_busy
);

	typedef enum logic [3:0] {
		ARB_IDLE,
		ARB_WAIT,
		ARB_RSP_CHAN,
		ARB_RSP_TIME,
		ARB_RSP_VALUE,
		ARB_RSP_TYPE,
		ARB_RSP_DONE,
		ARB_DAQ_HEAD,
		ARB_DAQ_TIME
	} arb_state_t;

	arb_state_t state;
	chan_sel_t  chan;
	chan_sel_t  rsp_pick;
	chan_sel_t  daq_pick;
	logic       rsp_found;
	logic       daq_found;
	frame_t     cur;
	daq_head_t  head;

	assign cur = frames[chan];
	assign arb_busy = state != ARB_IDLE;
	assign daq_data = param_data[31:0]; // Both buses share one output register.

	always_comb begin
		head.tag = cur.is_data ? `ENC_DAQ_TAG_DAT : `ENC_DAQ_TAG_MAG;
		head.chan = 6'(chan);
		head.value = cur.value;
	end

	// Highest-numbered waiting channel wins on each path.
	always_comb begin
		rsp_found = 1'b0;
		daq_found = 1'b0;
		rsp_pick = '0;
		daq_pick = '0;
		for (int i = 0; i < `ENC_CHANNELS; i++) begin
			if (frame_valid[i] && use_daq[i]) begin
				daq_found = 1'b1;
				daq_pick = chan_sel_t'(i);
			end
			if (frame_valid[i] && !use_daq[i]) begin
				rsp_found = 1'b1;
				rsp_pick = chan_sel_t'(i);
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ARB_IDLE;
			chan <= '0;
			frame_ack <= '0;
			invol_req <= 1'b0;
			daq_req <= 1'b0;
			param_write <= 1'b0;
			daq_valid <= 1'b0;
			daq_end <= 1'b0;
			cmd_done <= 1'b0;
		end else begin
			frame_ack <= '0;
			daq_valid <= 1'b0;
			daq_end <= 1'b0;
			cmd_done <= 1'b0;
			case (state)
				ARB_IDLE: begin
					if (|(frame_valid & use_daq))
						daq_req <= 1'b1;
					else if (|frame_valid)
						invol_req <= 1'b1;
					if (|frame_valid)
						state <= ARB_WAIT;
				end
				ARB_WAIT: begin
					if (invol_grant || daq_grant) begin
						invol_req <= 1'b0;
						daq_req <= 1'b0;
						state <= ARB_IDLE; // Frame may have gone away meanwhile.
						if (daq_grant && daq_found) begin
							chan <= daq_pick;
							state <= ARB_DAQ_HEAD;
						end else if (invol_grant && rsp_found) begin
							chan <= rsp_pick;
							state <= ARB_RSP_CHAN;
						end
					end
				end
				ARB_RSP_CHAN: begin
					param_write <= 1'b1;
					state <= ARB_RSP_TIME;
				end
				ARB_RSP_TIME:  state <= ARB_RSP_VALUE;
				ARB_RSP_VALUE: state <= ARB_RSP_TYPE;
				ARB_RSP_TYPE: begin
					frame_ack[chan] <= 1'b1;
					state <= ARB_RSP_DONE;
				end
				ARB_RSP_DONE: begin
					param_write <= 1'b0;
					cmd_done <= 1'b1;
					state <= ARB_IDLE;
				end
				ARB_DAQ_HEAD: begin
					daq_valid <= 1'b1;
					frame_ack[chan] <= 1'b1;
					state <= ARB_DAQ_TIME;
				end
				ARB_DAQ_TIME: begin
					daq_valid <= 1'b1;
					daq_end <= 1'b1;
					state <= ARB_IDLE;
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	// The frame stays stable until the cycle after its ack, so the last word still reads it.
	always_ff @(posedge clk) begin
		case (state)
			ARB_RSP_CHAN:  param_data <= 33'(chan);
			ARB_RSP_TIME:  param_data <= 33'(cur.start_time);
			ARB_RSP_VALUE: param_data <= 33'(cur.value);
			ARB_RSP_TYPE:  param_data <= 33'(cur.is_data);
			ARB_RSP_DONE:  param_data <= `ENC_RSP_DATA;
			ARB_DAQ_HEAD:  param_data <= 33'(head);
			ARB_DAQ_TIME:  param_data <= 33'(cur.start_time);
			default:       param_data <= param_data;
		endcase
	end

	assert property (@(posedge clk) disable iff (!arst_n) !(invol_req && daq_req));

	// A DAQ record is a head word followed by the closing time word.
	assert property (@(posedge clk) disable iff (!arst_n)
		daq_end |-> daq_valid && $past(daq_valid));

endmodule

//--- config_decoder.sv
`timescale 1ns/1ps
`include "encoder_settings.svh"

module config_decoder
	import encoder_cmd_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic [31:0] systime,
	input  logic [7:0]  cmd,
	input  logic        cmd_ready,
	input  logic [31:0] arg_data,
	input  logic        arb_busy,
	output logic        cfg_write,
	output chan_sel_t   cfg_sel,
	output chan_cfg_t   cfg,
	output logic        cmd_done
);

	// One state per argument word of the config command.
	typedef enum logic [2:0] {
		DEC_IDLE,
		DEC_DIV,
		DEC_DATA,
		DEC_MAG,
		DEC_USE
	} dec_state_t;

	dec_state_t state;
	logic       accept;

	// Commands wait while the arbiter owns the parameter bus.
	assign accept = state == DEC_IDLE && cmd_ready && !arb_busy;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= DEC_IDLE;
			cfg_write <= 1'b0;
			cmd_done <= 1'b0;
		end else begin
			cfg_write <= 1'b0;
			cmd_done <= 1'b0;
			case (state)
				DEC_IDLE: begin
					if (accept && cmd == `ENC_CMD_CONFIG)
						state <= DEC_DIV;
					else if (accept)
						cmd_done <= 1'b1; // Unknown commands are acknowledged at once.
				end
				DEC_DIV:  state <= DEC_DATA;
				DEC_DATA: state <= DEC_MAG;
				DEC_MAG:  state <= DEC_USE;
				DEC_USE: begin
					cfg_write <= 1'b1;
					cmd_done <= 1'b1;
					state <= DEC_IDLE;
				end
				default: state <= DEC_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			cfg_sel <= arg_data[$bits(chan_sel_t)-1:0];
		case (state)
			DEC_DIV:  cfg.divider <= arg_data[11:0];
			DEC_DATA: cfg.data_interval <= arg_data;
			DEC_MAG:  cfg.mag_interval <= arg_data;
			DEC_USE: begin
				cfg.use_daq <= arg_data[0];
				cfg.write_time <= systime;
			end
			default: cfg <= cfg;
		endcase
	end

	// A channel must see each configuration exactly once.
	assert property (@(posedge clk) disable iff (!arst_n) cfg_write |=> !cfg_write);

endmodule

//--- encoder_channel.sv
`timescale 1ns/1ps
`include "encoder_settings.svh"

module encoder_channel
	import encoder_cmd_pkg::*;
	import encoder_sample_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic [31:0] systime,
	input  logic        cfg_write,
	input  chan_cfg_t   cfg,
	input  logic        sensor_do,
	input  logic        frame_ack,
	output logic        sensor_clk,
	output logic        sensor_cs,
	output logic        frame_valid,
	output frame_t      frame,
	output logic        use_daq
);

	localparam int CNT_W = $clog2(`ENC_FRAME_BITS + 1);

	// Each state is named after the edge made when its phase ends.
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CS_FALL,
		ST_CLK_FALL,
		ST_CLK_RISE,
		ST_CS_RISE,
		ST_PRESENT
	} rd_state_t;

	chan_cfg_t                  cfg_q;
	rd_state_t                  state;
	logic [11:0]                div_cnt;
	logic [CNT_W-1:0]           bit_cnt;
	logic [31:0]                next_data;
	logic [31:0]                next_mag;
	logic                       data_pending;
	logic                       mag_pending;
	logic                       data_due;
	logic                       mag_due;
	logic                       enabled;
	logic                       start_frame;
	logic                       hold;
	logic                       phase_end;
	logic                       shift_en;
	logic                       present;
	logic [`ENC_FRAME_BITS-1:0] shift_q;
	logic [31:0]                start_q;
	logic                       is_data_q;

	assign enabled = cfg_q.divider != 12'd0;
	assign use_daq = cfg_q.use_daq;
	assign data_due = cfg_q.data_interval != 32'd0 && next_data == systime;
	assign mag_due = cfg_q.mag_interval != 32'd0 && next_mag == systime;
	assign start_frame = enabled && state == ST_IDLE && (data_pending || mag_pending);
	assign hold = state == ST_PRESENT && frame_valid && !frame_ack; // Previous frame not taken yet.
	assign phase_end = state != ST_IDLE && div_cnt == 12'd1 && !hold;
	assign present = phase_end && state == ST_PRESENT;
	// Data frames take each bit just before the fall that replaces it,
	// magnitude frames on the rising edge.
	assign shift_en = phase_end && (is_data_q ? state == ST_CLK_FALL : state == ST_CLK_RISE);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg_q <= '0;
			data_pending <= 1'b0;
			mag_pending <= 1'b0;
		end else if (cfg_write) begin
			cfg_q <= cfg;
			data_pending <= 1'b0;
			mag_pending <= 1'b0;
		end else begin
			if (start_frame && data_pending)
				data_pending <= 1'b0; // Data wins over magnitude.
			else if (start_frame)
				mag_pending <= 1'b0;
			if (data_due)
				data_pending <= 1'b1;
			if (mag_due)
				mag_pending <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (cfg_write) begin
			next_data <= cfg.write_time + cfg.data_interval;
			next_mag <= cfg.write_time + cfg.mag_interval;
		end else begin
			if (data_due)
				next_data <= next_data + cfg_q.data_interval;
			if (mag_due)
				next_mag <= next_mag + cfg_q.mag_interval;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			div_cnt <= '0;
			bit_cnt <= '0;
			is_data_q <= 1'b0;
			sensor_clk <= 1'b1;
			sensor_cs <= 1'b1;
			frame_valid <= 1'b0;
		end else if (!enabled) begin
			state <= ST_IDLE;
			sensor_clk <= 1'b1;
			sensor_cs <= 1'b1;
			frame_valid <= 1'b0;
		end else begin
			if (frame_ack)
				frame_valid <= 1'b0;
			if (start_frame) begin
				sensor_clk <= data_pending; // Clock level at CS fall selects the frame type.
				is_data_q <= data_pending;
				div_cnt <= cfg_q.divider;
				state <= ST_CS_FALL;
			end else if (phase_end) begin
				div_cnt <= cfg_q.divider;
				case (state)
					ST_CS_FALL: begin
						sensor_cs <= 1'b0;
						bit_cnt <= CNT_W'(`ENC_FRAME_BITS);
						state <= ST_CLK_FALL;
					end
					ST_CLK_FALL: begin
						sensor_clk <= 1'b0;
						state <= ST_CLK_RISE;
					end
					ST_CLK_RISE: begin
						sensor_clk <= 1'b1;
						bit_cnt <= bit_cnt - 1'b1;
						state <= (bit_cnt == CNT_W'(1)) ? ST_CS_RISE : ST_CLK_FALL;
					end
					ST_CS_RISE: begin
						sensor_cs <= 1'b1;
						state <= ST_PRESENT;
					end
					ST_PRESENT: begin
						frame_valid <= 1'b1;
						state <= ST_IDLE;
					end
					default: state <= ST_IDLE;
				endcase
			end else if (div_cnt > 12'd1) begin
				div_cnt <= div_cnt - 12'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start_frame)
			start_q <= systime;
		if (shift_en)
			shift_q <= {shift_q[`ENC_FRAME_BITS-2:0], sensor_do}; // MSB first.
		if (present) begin
			frame.value <= shift_q;
			frame.start_time <= start_q;
			frame.is_data <= is_data_q;
		end
	end

	// A disabled channel releases its sensor by the next cycle.
	assert property (@(posedge clk) disable iff (!arst_n) !enabled |=> sensor_cs);

	// Between frames the sensor clock only moves when a frame starts.
	assert property (@(posedge clk) disable iff (!arst_n)
		sensor_cs && enabled && !start_frame |=> $stable(sensor_clk));

endmodule

//--- encoder_sample_pkg.sv
`include "encoder_settings.svh"

package encoder_sample_pkg;

	// A finished sensor frame as held by a channel until it is reported.
	typedef struct packed {
		logic [`ENC_FRAME_BITS-1:0] value;
		logic [31:0]                start_time; // systime when the frame was started.
		logic                       is_data;    // Low for magnitude frames.
	} frame_t;

	// First word of a DAQ record; the second word is the start time.
	typedef struct packed {
		logic [7:0]                 tag;
		logic [5:0]                 chan;
		logic [`ENC_FRAME_BITS-1:0] value;
	} daq_head_t;

endpackage

//--- encoder_cmd_pkg.sv
`include "encoder_settings.svh"

package encoder_cmd_pkg;

	// Channel index as it arrives in the first argument of a command.
	typedef logic [$clog2(`ENC_CHANNELS)-1:0] chan_sel_t;

	// One channel's configuration.
	// A zero divider disables the channel, a zero interval disables that timer.
	typedef struct packed {
		logic [11:0] divider;       // System clocks per sensor clock phase.
		logic [31:0] data_interval;
		logic [31:0] mag_interval;
		logic        use_daq;       // Send frames as DAQ records.
		logic [31:0] write_time;    // Timer base for the first deadlines.
	} chan_cfg_t;

endpackage

//--- encoder_settings.svh
`ifndef ENCODER_SETTINGS_SVH
`define ENCODER_SETTINGS_SVH

// Number of sensors served by the hub.
`define ENC_CHANNELS 2

// Bits clocked out of one sensor per frame.
`define ENC_FRAME_BITS 18

// Command code that carries a channel configuration.
`define ENC_CMD_CONFIG 8'h2c

// Closing word of a response, sent together with cmd_done.
`define ENC_RSP_DATA 33'h1_0000_0061

// Top byte of the first DAQ word tells data frames from magnitude frames.
`define ENC_DAQ_TAG_DAT 8'h51
`define ENC_DAQ_TAG_MAG 8'h52

`endif
